//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // =========================================================================
    // Widths fixed by RV32I
    // =========================================================================
    localparam int XLEN       = 32;
    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // Field positions, LSB of each field
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    // =========================================================================
    // Opcodes of the supported instruction classes
    // =========================================================================
    localparam logic [OPCODE_W-1:0] OP_LUI = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_IMM = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_REG = 7'b0110011;

    // funct3 codes, shared by OP_IMM and OP_REG
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // funct7 codes, ALT picks SUB and SRA
    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

endpackage

//--- hw/core_ctrl_pkg.sv
package core_ctrl_pkg;

    // =========================================================================
    // ALU operation codes
    // =========================================================================
    // Encoded 0 to 9
    // Codes 10 to 15 stay unused in this datapath
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_OR   = 4'd2,
        ALU_AND  = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // Shift amount width taken from the low bits of operand B
    localparam int SHAMT_W = 5;

endpackage

//--- hw/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs1_addr_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs2_addr_i,
    input  logic                                wr_en_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   wr_addr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]         wr_data_i,
    output logic [rv_isa_pkg::XLEN-1:0]         rs1_data_o,
    output logic [rv_isa_pkg::XLEN-1:0]         rs2_data_o
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // x0 reads zero and a same-cycle write is passed straight through
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en_i && (wr_addr_i == addr)) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    // All registers clear on reset and x0 is never written
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Both read ports are combinational
    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                instr_valid_i,
    input  logic [rv_isa_pkg::INSTR_W-1:0]      instr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]         rf_rs1_data_i,
    input  logic [rv_isa_pkg::XLEN-1:0]         rf_rs2_data_i,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   rf_rs1_addr_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   rf_rs2_addr_o,
    output logic                                ex_valid_o,
    output core_ctrl_pkg::alu_op_e              ex_alu_op_o,
    output logic                                ex_use_imm_o,
    output logic [rv_isa_pkg::XLEN-1:0]         ex_imm_o,
    output logic [rv_isa_pkg::XLEN-1:0]         ex_rs1_data_o,
    output logic [rv_isa_pkg::XLEN-1:0]         ex_rs2_data_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   ex_rs1_addr_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   ex_rs2_addr_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   ex_rd_addr_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [OPCODE_W-1:0]   opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic [FUNCT7_W-1:0]   funct7;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_sh;
    logic [XLEN-1:0]       imm_u;
    logic                  is_shift;
    logic                  dec_valid;
    alu_op_e               dec_alu_op;
    logic                  dec_use_imm;
    logic [XLEN-1:0]       dec_imm;

    // Operation implied by funct3 alone, funct7 ALT handled by the caller
    function automatic alu_op_e base_op(input logic [FUNCT3_W-1:0] f3);
        case (f3)
            F3_ADD_SUB: return ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    // =========================================================================
    // Field extraction and immediates
    // =========================================================================
    assign opcode  = instr_i[OPCODE_W-1:0];
    assign funct3  = instr_i[FUNCT3_LSB +: FUNCT3_W];
    assign funct7  = instr_i[FUNCT7_LSB +: FUNCT7_W];
    assign rd_addr = instr_i[RD_LSB +: REG_ADDR_W];
    assign rs2_addr = instr_i[RS2_LSB +: REG_ADDR_W];

    // LUI reads x0 so the ALU computes 0 + imm_u
    assign rs1_addr = (opcode == OP_LUI) ? '0 : instr_i[RS1_LSB +: REG_ADDR_W];

    // I-type, sign-extended
    assign imm_i  = {{(XLEN-12){instr_i[INSTR_W-1]}}, instr_i[INSTR_W-1:RS2_LSB]};
    // Shamt, zero-extended
    assign imm_sh = {{(XLEN-SHAMT_W){1'b0}}, instr_i[RS2_LSB +: SHAMT_W]};
    // U-type, low 12 bits zero
    assign imm_u  = {instr_i[INSTR_W-1:FUNCT3_LSB], 12'b0};

    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

    // Register file read ports
    assign rf_rs1_addr_o = rs1_addr;
    assign rf_rs2_addr_o = rs2_addr;

    // =========================================================================
    // Control decode
    // =========================================================================
    always_comb begin
        // Anything not matched below stays a NOP
        dec_valid   = 1'b0;
        dec_alu_op  = base_op(funct3);
        dec_use_imm = 1'b0;
        dec_imm     = imm_i;
        case (opcode)
            OP_LUI: begin
                dec_valid   = 1'b1;
                dec_alu_op  = ALU_ADD;
                dec_use_imm = 1'b1;
                dec_imm     = imm_u;
            end
            OP_IMM: begin
                dec_use_imm = 1'b1;
                if (!is_shift) begin
                    dec_valid = 1'b1;
                end else begin
                    // Shifts carry funct7 in the upper immediate bits
                    dec_imm = imm_sh;
                    if (funct7 == F7_BASE) begin
                        dec_valid = 1'b1;
                    end else if (funct7 == F7_ALT && funct3 == F3_SRL_SRA) begin
                        dec_valid  = 1'b1;
                        dec_alu_op = ALU_SRA;
                    end
                end
            end
            OP_REG: begin
                if (funct7 == F7_BASE) begin
                    dec_valid = 1'b1;
                end else if (funct7 == F7_ALT) begin
                    // Only SUB and SRA exist in the ALT encoding
                    if (funct3 == F3_ADD_SUB) begin
                        dec_valid  = 1'b1;
                        dec_alu_op = ALU_SUB;
                    end else if (funct3 == F3_SRL_SRA) begin
                        dec_valid  = 1'b1;
                        dec_alu_op = ALU_SRA;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    // =========================================================================
    // Decode to execute register
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= instr_valid_i && dec_valid;
        end
    end

    // Payload only follows a strobed instruction
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            ex_alu_op_o   <= dec_alu_op;
            ex_use_imm_o  <= dec_use_imm;
            ex_imm_o      <= dec_imm;
            ex_rs1_data_o <= rf_rs1_data_i;
            ex_rs2_data_o <= rf_rs2_data_i;
            ex_rs1_addr_o <= rs1_addr;
            ex_rs2_addr_o <= rs2_addr;
            ex_rd_addr_o  <= rd_addr;
        end
    end

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                                ex_valid_i,
    input  core_ctrl_pkg::alu_op_e              ex_alu_op_i,
    input  logic                                ex_use_imm_i,
    input  logic [rv_isa_pkg::XLEN-1:0]         ex_imm_i,
    input  logic [rv_isa_pkg::XLEN-1:0]         ex_rs1_data_i,
    input  logic [rv_isa_pkg::XLEN-1:0]         ex_rs2_data_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   ex_rs1_addr_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   ex_rs2_addr_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   ex_rd_addr_i,
    input  logic                                wb_valid_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   wb_rd_addr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]         wb_data_i,
    output logic                                res_valid_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   res_rd_addr_o,
    output logic [rv_isa_pkg::XLEN-1:0]         res_data_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    rs2_fwd;
    logic [XLEN-1:0]    op_b;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    alu_result;

    // Result stage value wins over the stale decode-time read
    function automatic logic [XLEN-1:0] bypass(input logic [REG_ADDR_W-1:0] addr,
                                               input logic [XLEN-1:0]       data);
        if (wb_valid_i && (addr != '0) && (addr == wb_rd_addr_i)) begin
            return wb_data_i;
        end
        return data;
    endfunction

    // =========================================================================
    // Operand selection
    // =========================================================================
    always_comb begin
        op_a    = bypass(ex_rs1_addr_i, ex_rs1_data_i);
        rs2_fwd = bypass(ex_rs2_addr_i, ex_rs2_data_i);
    end

    assign op_b = ex_use_imm_i ? ex_imm_i : rs2_fwd;

    // Shifts only look at the low five bits
    assign shamt = op_b[SHAMT_W-1:0];

    // =========================================================================
    // ALU
    // =========================================================================
    always_comb begin
        case (ex_alu_op_i)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            // Compares give 0 or 1
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            default:  alu_result = '0;
        endcase
    end

    // Passed straight to the result register in the same cycle
    assign res_valid_o   = ex_valid_i;
    assign res_rd_addr_o = ex_rd_addr_i;
    assign res_data_o    = alu_result;

endmodule

//--- hw/result_stage.sv
`timescale 1ns/10ps

module result_stage (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                res_valid_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   res_rd_addr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]         res_data_i,
    output logic                                result_valid_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   result_rd_o,
    output logic [rv_isa_pkg::XLEN-1:0]         result_data_o,
    output logic                                rf_wr_en_o,
    output logic [rv_isa_pkg::XLEN-1:0]         instret_o
);
    import rv_isa_pkg::*;

    // Result strobe and retire counter
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
            instret_o      <= '0;
        end else begin
            result_valid_o <= res_valid_i;
            // Counts the strobe of the previous cycle and wraps at 2^XLEN
            if (result_valid_o) begin
                instret_o <= instret_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            result_rd_o   <= res_rd_addr_i;
            result_data_o <= res_data_i;
        end
    end

    // x0 still retires and strobes but is never written
    assign rf_wr_en_o = result_valid_o && (result_rd_o != '0);

endmodule

//--- hw/rv32i_int_core.sv
`timescale 1ns/10ps

module rv32i_int_core (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                instr_valid_i,
    input  logic [rv_isa_pkg::INSTR_W-1:0]      instr_i,
    output logic                                result_valid_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   result_rd_o,
    output logic [rv_isa_pkg::XLEN-1:0]         result_data_o,
    output logic [rv_isa_pkg::XLEN-1:0]         instret_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    // Register file read side
    logic [REG_ADDR_W-1:0] rf_rs1_addr;
    logic [REG_ADDR_W-1:0] rf_rs2_addr;
    logic [XLEN-1:0]       rf_rs1_data;
    logic [XLEN-1:0]       rf_rs2_data;
    logic                  rf_wr_en;

    // Decode to execute
    logic                  ex_valid;
    alu_op_e               ex_alu_op;
    logic                  ex_use_imm;
    logic [XLEN-1:0]       ex_imm;
    logic [XLEN-1:0]       ex_rs1_data;
    logic [XLEN-1:0]       ex_rs2_data;
    logic [REG_ADDR_W-1:0] ex_rs1_addr;
    logic [REG_ADDR_W-1:0] ex_rs2_addr;
    logic [REG_ADDR_W-1:0] ex_rd_addr;

    // Execute to result
    logic                  res_valid;
    logic [REG_ADDR_W-1:0] res_rd_addr;
    logic [XLEN-1:0]       res_data;

    // =========================================================================
    // Stage instances
    // =========================================================================
    decode_stage u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .rf_rs1_addr_o (rf_rs1_addr),
        .rf_rs2_addr_o (rf_rs2_addr),
        .ex_valid_o    (ex_valid),
        .ex_alu_op_o   (ex_alu_op),
        .ex_use_imm_o  (ex_use_imm),
        .ex_imm_o      (ex_imm),
        .ex_rs1_data_o (ex_rs1_data),
        .ex_rs2_data_o (ex_rs2_data),
        .ex_rs1_addr_o (ex_rs1_addr),
        .ex_rs2_addr_o (ex_rs2_addr),
        .ex_rd_addr_o  (ex_rd_addr)
    );

    // Written from the result stage, read by decode
    register_file u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rf_rs1_addr),
        .rs2_addr_i (rf_rs2_addr),
        .wr_en_i    (rf_wr_en),
        .wr_addr_i  (result_rd_o),
        .wr_data_i  (result_data_o),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data)
    );

    // Bypass taps the registered result outputs
    execute_stage u_execute (
        .ex_valid_i    (ex_valid),
        .ex_alu_op_i   (ex_alu_op),
        .ex_use_imm_i  (ex_use_imm),
        .ex_imm_i      (ex_imm),
        .ex_rs1_data_i (ex_rs1_data),
        .ex_rs2_data_i (ex_rs2_data),
        .ex_rs1_addr_i (ex_rs1_addr),
        .ex_rs2_addr_i (ex_rs2_addr),
        .ex_rd_addr_i  (ex_rd_addr),
        .wb_valid_i    (result_valid_o),
        .wb_rd_addr_i  (result_rd_o),
        .wb_data_i     (result_data_o),
        .res_valid_o   (res_valid),
        .res_rd_addr_o (res_rd_addr),
        .res_data_o    (res_data)
    );

    result_stage u_result (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .res_valid_i    (res_valid),
        .res_rd_addr_i  (res_rd_addr),
        .res_data_i     (res_data),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_data_o  (result_data_o),
        .rf_wr_en_o     (rf_wr_en),
        .instret_o      (instret_o)
    );

endmodule

//--- testbench/tb_rv32i_int_core.sv
`timescale 1ns/10ps

module tb_rv32i_int_core;
    import rv_isa_pkg::*;

    logic                  clk;
    logic                  rst_n_i;
    logic                  instr_valid_i;
    logic [INSTR_W-1:0]    instr_i;
    logic                  result_valid_o;
    logic [REG_ADDR_W-1:0] result_rd_o;
    logic [XLEN-1:0]       result_data_o;
    logic [XLEN-1:0]       instret_o;

    // Reference model and scoreboard
    logic                  issue_recog;
    logic [XLEN-1:0]       model_regs [NUM_REGS];
    logic [REG_ADDR_W-1:0] exp_rd_q [$];
    logic [XLEN-1:0]       exp_data_q [$];
    string                 exp_name_q [$];
    string                 test_name;
    integer                seed;
    int                    issued;
    int                    strobes;
    int                    cycle_count;

    rv32i_int_core uut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_data_o  (result_data_o),
        .instret_o      (instret_o)
    );

    always #5 clk = ~clk;

    // ========================================================================
    // Failure reporting
    // ========================================================================
    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped after the first failure");
    endtask

    task automatic report_value(input string name, input string what,
                                input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        $display("Error: test %s, %s expected 0x%08h actual 0x%08h", name, what, exp, act);
        stop_run();
    endtask

    task automatic report_problem(input string msg);
        $display("Failure in test %s: %s", test_name, msg);
        stop_run();
    endtask

    // ========================================================================
    // Instruction encoding and the ISA reference
    // ========================================================================
    function automatic logic [31:0] encode_itype(input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] encode_rtype(input logic alt, input logic [2:0] f3,
                                                 input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [4:0] rs2);
        return {(alt ? F7_ALT : F7_BASE), rs2, rs1, f3, rd, OP_REG};
    endfunction

    // Result of one integer op as the RV32I spec defines it
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else     res = a >> b[4:0];
            end
        endcase
        return res;
    endfunction

    // Nonzero register index
    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    endfunction

    // ========================================================================
    // Stimulus with one instruction per falling edge
    // ========================================================================
    task automatic drive(input logic [31:0] instr, input logic recog);
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        issue_recog   = recog;
        issued++;
    endtask

    task automatic expect_result(input logic [4:0] rd, input logic [31:0] data);
        exp_name_q.push_back(test_name);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
        if (rd != 5'd0) model_regs[rd] = data;
    endtask

    task automatic issue_imm(input logic [2:0] f3, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] data;
        logic        alt;
        alt  = (f3 == F3_SRL_SRA) && imm[10];
        data = ref_alu(f3, alt, model_regs[rs1], {{20{imm[11]}}, imm});
        drive(encode_itype(f3, rd, rs1, imm), 1'b1);
        expect_result(rd, data);
    endtask

    task automatic issue_reg(input logic alt, input logic [2:0] f3, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] data;
        data = ref_alu(f3, alt, model_regs[rs1], model_regs[rs2]);
        drive(encode_rtype(alt, f3, rd, rs1, rs2), 1'b1);
        expect_result(rd, data);
    endtask

    task automatic issue_lui(input logic [4:0] rd, input logic [19:0] imm);
        drive({imm, rd, OP_LUI}, 1'b1);
        expect_result(rd, {imm, 12'b0});
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid_i = 1'b0;
            issue_recog   = 1'b0;
            instr_i       = '0;
        end
    endtask

    // ========================================================================
    // Checks
    // ========================================================================
    // Fixed two-cycle latency in both directions
    assert property (@(posedge clk) disable iff (!rst_n_i) issue_recog |-> ##2 result_valid_o)
        else report_problem("no result strobe two cycles after a recognised instruction");
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     result_valid_o |-> $past(issue_recog, 2))
        else report_problem("result strobe without a recognised instruction before it");
    assert property (@(posedge clk) !rst_n_i |-> (!result_valid_o && instret_o == '0))
        else report_problem("outputs are not cleared during reset");
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     result_valid_o |=> (instret_o == $past(instret_o) + 1))
        else report_problem("instret did not step after a result strobe");

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : check_results
        string           name;
        logic [4:0]      rd;
        logic [31:0]     data;
        if (rst_n_i && result_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                report_problem("result strobe with no instruction outstanding");
            end else begin
                name = exp_name_q.pop_front();
                rd   = exp_rd_q.pop_front();
                data = exp_data_q.pop_front();
                strobes++;
                assert (result_rd_o == rd) else report_value(name, "rd", rd, result_rd_o);
                assert (result_data_o == data)
                    else report_value(name, "data", data, result_data_o);
            end
        end
    end

    // Limit scales with the instructions issued so far
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 50 * issued + 100) begin
            report_problem("timeout, results stopped arriving");
        end
    end

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  prev_rd;
        logic [4:0]  prev2_rd;
        logic [2:0]  f3;
        logic        alt;
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        issue_recog   = 1'b0;
        seed          = 78927;
        issued        = 0;
        strobes       = 0;
        cycle_count   = 0;
        test_name     = "reset_state";
        for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        // Nothing comes out on its own and registers read zero
        go_idle(4);
        assert (instret_o == '0) else report_value(test_name, "instret", 0, instret_o);
        issue_reg(1'b0, F3_ADD_SUB, 5'd1, 5'd0, 5'd0);
        issue_reg(1'b0, F3_ADD_SUB, 5'd2, 5'd1, 5'd0);
        issue_reg(1'b0, F3_OR, 5'd3, 5'd9, 5'd17);
        go_idle(4);

        // Load every register and then run random immediate ops
        test_name = "imm_arith";
        for (int i = 1; i < NUM_REGS; i++) begin
            r = $random(seed);
            issue_lui(5'(i), r[31:12]);
            issue_imm(F3_ADD_SUB, 5'(i), 5'(i), r[11:0]);
        end
        for (int i = 0; i < 60; i++) begin
            r  = $random(seed);
            f3 = r[2:0];
            // Shift codes become compares here and shifts come later
            if (f3 == F3_SLL) f3 = F3_SLT;
            if (f3 == F3_SRL_SRA) f3 = F3_SLTU;
            issue_imm(f3, rand_reg(), rand_reg(), r[31:20]);
        end
        go_idle(3);

        // Back to back with sources one and two instructions apart
        test_name = "reg_arith";
        prev_rd   = rand_reg();
        prev2_rd  = rand_reg();
        for (int i = 0; i < 80; i++) begin
            r   = $random(seed);
            f3  = r[2:0];
            alt = r[3] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA);
            rd  = rand_reg();
            if (i % 2 == 0) issue_reg(alt, f3, rd, prev_rd, prev2_rd);
            else            issue_reg(alt, f3, rd, prev2_rd, prev_rd);
            prev2_rd = prev_rd;
            prev_rd  = rd;
        end
        go_idle(3);

        test_name = "lui_shift";
        for (int i = 0; i < 20; i++) begin
            r  = $random(seed);
            rd = rand_reg();
            // Half the sources get the sign bit set for SRAI
            issue_lui(rd, {r[0], r[30:12]});
            issue_imm(F3_SLL, rand_reg(), rd, {7'b0, r[24:20]});
            issue_imm(F3_SRL_SRA, rand_reg(), rd, {7'b0, r[29:25]});
            issue_imm(F3_SRL_SRA, rand_reg(), rd, {F7_ALT, r[9:5]});
        end
        go_idle(3);

        // x0 writes strobe but never stick
        // Unknown opcodes are NOPs
        test_name = "x0_nop";
        issue_imm(F3_ADD_SUB, 5'd0, 5'd5, 12'h07b);
        issue_reg(1'b0, F3_ADD_SUB, 5'd7, 5'd0, 5'd5);
        drive(32'h0000_2083, 1'b0);
        issue_reg(1'b0, F3_OR, 5'd8, 5'd0, 5'd0);
        drive(32'h0011_2023, 1'b0);
        drive(32'h0000_0073, 1'b0);
        issue_reg(1'b0, F3_ADD_SUB, 5'd0, 5'd3, 5'd4);
        issue_reg(1'b0, F3_XOR, 5'd9, 5'd0, 5'd6);
        go_idle(2);

        while (exp_rd_q.size() != 0) @(negedge clk);
        go_idle(3);
        if (instret_o == XLEN'(strobes)) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            report_value("final", "instret", strobes, instret_o);
        end
    end

endmodule

//--- build.f
hw/rv_isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/rv32i_int_core.sv
testbench/tb_rv32i_int_core.sv

//--- Bender.yml
package:
  name: rv32i_int_core

sources:
  - hw/rv_isa_pkg.sv
  - hw/core_ctrl_pkg.sv
  - hw/register_file.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/result_stage.sv
  - hw/rv32i_int_core.sv
  - target: simulation
    files:
      - testbench/tb_rv32i_int_core.sv
